//--- src/opc_pkg.sv
package opc_pkg;

   typedef logic [15:0] addr_t;
   typedef logic [15:0] data_t;
   typedef logic [7:0]  byte_t;
   typedef logic [3:0]  nibble_t;

   // Active-low segments, bit 6 is g and bit 0 is a
   typedef logic [6:0]  seg_t;

   // Even address of each two-word register pair
   localparam addr_t UART_BASE = 16'hFE08;
   localparam addr_t DISP_BASE = 16'hFE0A;

   localparam data_t UNMAPPED_DATA = 16'hFFFF;

   // Standard hex font for a common-anode display
   function automatic seg_t hex_to_seg(input nibble_t digit);
      seg_t pattern;
      case (digit)
         4'h0: pattern = 7'h40;
         4'h1: pattern = 7'h79;
         4'h2: pattern = 7'h24;
         4'h3: pattern = 7'h30;
         4'h4: pattern = 7'h19;
         4'h5: pattern = 7'h12;
         4'h6: pattern = 7'h02;
         4'h7: pattern = 7'h78;
         4'h8: pattern = 7'h00;
         4'h9: pattern = 7'h10;
         4'hA: pattern = 7'h08;
         4'hB: pattern = 7'h03;
         4'hC: pattern = 7'h46;
         4'hD: pattern = 7'h21;
         4'hE: pattern = 7'h06;
         default: pattern = 7'h0E;
      endcase
      return pattern;
   endfunction

endpackage

//--- src/wb_bus_if.sv
`timescale 1ns/1ps

// One Wishbone classic link from the decoder to a single slave
interface wb_bus_if import opc_pkg::*; ();
   logic  cyc;
   logic  stb;
   logic  we;
   addr_t adr;
   data_t dat_w;
   data_t dat_r;
   logic  ack;

   modport master (output cyc, stb, we, adr, dat_w, input dat_r, ack);
   modport slave  (input cyc, stb, we, adr, dat_w, output dat_r, ack);
endinterface

// Settings from the display registers to the seven-segment driver
interface disp_link_if import opc_pkg::*; ();
   data_t   value;
   nibble_t duty;
   logic    use_switches;

   modport source (output value, duty, use_switches);
   modport sink   (input value, duty, use_switches);
endinterface

//--- src/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder import opc_pkg::*; #(
   parameter int RAM_AW = 14
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        wb_cyc,
   input  logic        wb_stb,
   input  logic        wb_we,
   input  addr_t       wb_adr,
   input  data_t       wb_dat_w,
   output data_t       wb_dat_r,
   output logic        wb_ack,
   wb_bus_if.master    ram_bus,
   wb_bus_if.master    uart_bus,
   wb_bus_if.master    disp_bus
);

   logic ram_sel;
   logic uart_sel;
   logic disp_sel;
   logic unmapped;
   logic um_ack;

   assign ram_sel  = (wb_adr[15:RAM_AW] == '0);
   assign uart_sel = ({wb_adr[15:1], 1'b0} == UART_BASE);
   assign disp_sel = ({wb_adr[15:1], 1'b0} == DISP_BASE);
   assign unmapped = !(ram_sel || uart_sel || disp_sel);

   // Shared request lines, stb goes only to the addressed slave
   assign ram_bus.cyc   = wb_cyc;
   assign ram_bus.we    = wb_we;
   assign ram_bus.adr   = wb_adr;
   assign ram_bus.dat_w = wb_dat_w;
   assign ram_bus.stb   = wb_stb && ram_sel;

   assign uart_bus.cyc   = wb_cyc;
   assign uart_bus.we    = wb_we;
   assign uart_bus.adr   = wb_adr;
   assign uart_bus.dat_w = wb_dat_w;
   assign uart_bus.stb   = wb_stb && uart_sel;

   assign disp_bus.cyc   = wb_cyc;
   assign disp_bus.we    = wb_we;
   assign disp_bus.adr   = wb_adr;
   assign disp_bus.dat_w = wb_dat_w;
   assign disp_bus.stb   = wb_stb && disp_sel;

   // Nobody answers an unmapped address, so the decoder acks it itself
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         um_ack <= 1'b0;
      end else begin
         um_ack <= wb_cyc && wb_stb && unmapped && !um_ack;
      end
   end

   always_comb begin
      if (ram_sel) begin
         wb_dat_r = ram_bus.dat_r;
         wb_ack   = ram_bus.ack;
      end else if (uart_sel) begin
         wb_dat_r = uart_bus.dat_r;
         wb_ack   = uart_bus.ack;
      end else if (disp_sel) begin
         wb_dat_r = disp_bus.dat_r;
         wb_ack   = disp_bus.ack;
      end else begin
         wb_dat_r = UNMAPPED_DATA;
         wb_ack   = um_ack;
      end
   end

   a_one_slave_stb: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0({ram_bus.stb, uart_bus.stb, disp_bus.stb}));

   // An ack must answer a strobe still held by the master
   a_ack_needs_stb: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(wb_ack) |-> wb_stb);

endmodule

//--- src/ram_block.sv
`timescale 1ns/1ps

module ram_block import opc_pkg::*; #(
   parameter int RAM_AW = 14
) (
   input  logic     clk,
   input  logic     rst_n,
   wb_bus_if.slave  bus
);

   data_t mem [2**RAM_AW];

   logic              req;
   logic [RAM_AW-1:0] word_adr;

   // New request only while no ack is out, so ack never repeats
   assign req      = bus.cyc && bus.stb && !bus.ack;
   assign word_adr = bus.adr[RAM_AW-1:0];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         bus.ack <= 1'b0;
      end else begin
         bus.ack <= req;
      end
   end

   // Array and read data register
   always_ff @(posedge clk) begin
      if (req) begin
         if (bus.we) begin
            mem[word_adr] <= bus.dat_w;
         end
         bus.dat_r <= mem[word_adr];
      end
   end

endmodule

//--- src/uart.sv
`timescale 1ns/1ps

module uart import opc_pkg::*; #(
   parameter int CLK_HZ = 25_000_000,
   parameter int BAUD   = 1_562_500
) (
   input  logic     clk,
   input  logic     rst_n,
   wb_bus_if.slave  bus,
   input  logic     rxd,
   output logic     txd
);

   localparam int DIV  = CLK_HZ / BAUD;
   localparam int CW   = $clog2(DIV);
   localparam int HALF = DIV / 2 - 1;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_t;

   tx_state_t       tx_state;
   logic [CW-1:0]   tx_cnt;
   logic [2:0]      tx_bit;
   byte_t           tx_shift;
   logic            tx_busy;
   logic            tx_tick;

   logic            rx_meta;
   logic            rx_s;
   logic            rx_active;
   logic [CW-1:0]   rx_cnt;
   logic [3:0]      rx_bit;
   byte_t           rx_shift;
   byte_t           rx_byte;
   logic            rx_valid;

   logic            req;
   logic            wr_data;
   logic            rd_data;

   assign req     = bus.cyc && bus.stb && !bus.ack;
   assign wr_data = req && bus.we && !bus.adr[0];
   assign rd_data = req && !bus.we && !bus.adr[0];
   assign tx_busy = (tx_state != TX_IDLE);
   assign tx_tick = (tx_cnt == CW'(DIV - 1));

   // Bus side, data register at the even address and status at the odd one
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         bus.ack <= 1'b0;
      end else begin
         bus.ack <= req;
      end
      if (req) begin
         bus.dat_r <= bus.adr[0] ? {14'b0, tx_busy, rx_valid} : {8'h00, rx_byte};
      end
   end

   // Transmitter, a write while busy is simply lost
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tx_state <= TX_IDLE;
         tx_cnt   <= '0;
         tx_bit   <= '0;
         tx_shift <= '0;
         txd      <= 1'b1;
      end else begin
         tx_cnt <= tx_tick ? '0 : tx_cnt + 1'b1;
         case (tx_state)
            TX_IDLE: begin
               tx_cnt <= '0;
               if (wr_data) begin
                  tx_shift <= bus.dat_w[7:0];
                  txd      <= 1'b0;
                  tx_state <= TX_START;
               end
            end
            TX_START: begin
               if (tx_tick) begin
                  txd      <= tx_shift[0];
                  tx_bit   <= '0;
                  tx_state <= TX_DATA;
               end
            end
            TX_DATA: begin
               if (tx_tick) begin
                  if (tx_bit == 3'd7) begin
                     txd      <= 1'b1;
                     tx_state <= TX_STOP;
                  end else begin
                     txd      <= tx_shift[1];
                     tx_shift <= tx_shift >> 1;
                     tx_bit   <= tx_bit + 1'b1;
                  end
               end
            end
            default: begin
               if (tx_tick) begin
                  tx_state <= TX_IDLE;
               end
            end
         endcase
      end
   end

   // Receiver, bit 0 is the start bit and bit 9 the stop bit
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rx_meta   <= 1'b1;
         rx_s      <= 1'b1;
         rx_active <= 1'b0;
         rx_cnt    <= '0;
         rx_bit    <= '0;
         rx_valid  <= 1'b0;
      end else begin
         rx_meta <= rxd;
         rx_s    <= rx_meta;
         if (rd_data) begin
            rx_valid <= 1'b0;
         end
         if (!rx_active) begin
            rx_cnt <= '0;
            rx_bit <= '0;
            if (!rx_s) begin
               rx_active <= 1'b1;
            end
         end else begin
            rx_cnt <= (rx_cnt == CW'(DIV - 1)) ? '0 : rx_cnt + 1'b1;
            if (rx_cnt == CW'(HALF)) begin
               rx_bit <= rx_bit + 1'b1;
               if (rx_bit == 4'd0 && rx_s) begin
                  // Glitch, not a real start bit
                  rx_active <= 1'b0;
               end else if (rx_bit == 4'd9) begin
                  rx_byte   <= rx_shift;
                  rx_valid  <= 1'b1;
                  rx_active <= 1'b0;
               end else if (rx_bit != 4'd0) begin
                  rx_shift <= {rx_s, rx_shift[7:1]};
               end
            end
         end
      end
   end

   a_idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
      (tx_state == TX_IDLE) |-> txd);

endmodule

//--- src/display_regs.sv
`timescale 1ns/1ps

module display_regs import opc_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   wb_bus_if.slave     bus,
   disp_link_if.source disp
);

   data_t      value;
   // Bit 4 selects the switches, bits 3..0 hold the duty
   logic [4:0] ctrl;
   logic       req;

   assign req = bus.cyc && bus.stb && !bus.ack;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         bus.ack <= 1'b0;
         value   <= '0;
         ctrl    <= 5'h0F;
      end else begin
         bus.ack <= req;
         if (req && bus.we) begin
            if (bus.adr[0]) begin
               ctrl <= bus.dat_w[4:0];
            end else begin
               value <= bus.dat_w;
            end
         end
      end
   end

   // Read back of both registers
   always_ff @(posedge clk) begin
      if (req) begin
         bus.dat_r <= bus.adr[0] ? {11'b0, ctrl} : value;
      end
   end

   assign disp.value        = value;
   assign disp.duty         = ctrl[3:0];
   assign disp.use_switches = ctrl[4];

endmodule

//--- src/seven_seg_display.sv
`timescale 1ns/1ps

module seven_seg_display import opc_pkg::*; #(
   parameter int REFRESH_BITS = 8
) (
   input  logic       clk,
   input  logic       rst_n,
   disp_link_if.sink  disp,
   input  logic [7:0] sw,
   output seg_t       seg,
   output logic [3:0] an
);

   logic [REFRESH_BITS+1:0] refresh;
   logic [1:0]              digit;
   data_t                   shown;
   nibble_t                 nib;
   logic                    lit;

   // Free running, the top two bits step through the digits
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         refresh <= '0;
      end else begin
         refresh <= refresh + 1'b1;
      end
   end

   assign digit = refresh[REFRESH_BITS+1:REFRESH_BITS];
   assign shown = disp.use_switches ? {8'h00, sw} : disp.value;
   assign nib   = shown[digit*4 +: 4];
   assign seg   = hex_to_seg(nib);

   // Brightness comes from the share of each 16-cycle slot that is lit
   assign lit = (refresh[3:0] <= disp.duty);

   always_comb begin
      an = 4'hF;
      if (lit) begin
         an[digit] = 1'b0;
      end
   end

   a_one_anode: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(~an));

endmodule

//--- src/opc_system.sv
`timescale 1ns/1ps

module opc_system import opc_pkg::*; #(
   parameter int RAM_AW       = 14,
   parameter int CLK_HZ       = 25_000_000,
   parameter int BAUD         = 1_562_500,
   parameter int REFRESH_BITS = 8
) (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       wb_cyc,
   input  logic       wb_stb,
   input  logic       wb_we,
   input  addr_t      wb_adr,
   input  data_t      wb_dat_w,
   output data_t      wb_dat_r,
   output logic       wb_ack,
   input  logic [7:0] sw,
   output logic [7:0] led,
   input  logic       rxd,
   output logic       txd,
   output seg_t       seg,
   output logic [3:0] an
);

   wb_bus_if    ram_bus ();
   wb_bus_if    uart_bus ();
   wb_bus_if    disp_bus ();
   disp_link_if disp_link ();

   bus_decoder #(.RAM_AW(RAM_AW)) i_decoder (
      .clk      (clk),
      .rst_n    (rst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack),
      .ram_bus  (ram_bus.master),
      .uart_bus (uart_bus.master),
      .disp_bus (disp_bus.master)
   );

   ram_block #(.RAM_AW(RAM_AW)) i_ram (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (ram_bus.slave)
   );

   uart #(.CLK_HZ(CLK_HZ), .BAUD(BAUD)) i_uart (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (uart_bus.slave),
      .rxd   (rxd),
      .txd   (txd)
   );

   display_regs i_disp_regs (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (disp_bus.slave),
      .disp  (disp_link.source)
   );

   seven_seg_display #(.REFRESH_BITS(REFRESH_BITS)) i_display (
      .clk   (clk),
      .rst_n (rst_n),
      .disp  (disp_link.sink),
      .sw    (sw),
      .seg   (seg),
      .an    (an)
   );

   assign led = sw;

endmodule

//--- tb/tb_opc_system.sv
`timescale 1ns/1ps

module tb_opc_system import opc_pkg::*; ();

   localparam int    RAM_AW       = 14;
   localparam int    REFRESH_BITS = 6;
   localparam int    ACK_LIMIT    = 20;
   localparam int    POLL_LIMIT   = 200;
   localparam addr_t RAM_MASK     = addr_t'((1 << RAM_AW) - 1);
   localparam addr_t UART_STATUS  = UART_BASE + 16'd1;
   localparam addr_t DISP_CTRL    = DISP_BASE + 16'd1;

   // Active-low common-anode hex font with bit 6 as segment g
   localparam seg_t SEG_FONT [16] = '{
      7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
      7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
   };
   localparam byte_t UART_BYTES [4] = '{8'h55, 8'hA3, 8'h00, 8'hFF};

   logic       clk;
   logic       rst_n;
   logic       wb_cyc;
   logic       wb_stb;
   logic       wb_we;
   addr_t      wb_adr;
   data_t      wb_dat_w;
   data_t      wb_dat_r;
   logic       wb_ack;
   logic [7:0] sw;
   logic [7:0] led;
   logic       rxd;
   logic       txd;
   seg_t       seg;
   logic [3:0] an;

   int          checks = 0;
   int          errors = 0;
   logic [31:0] rng_state = 32'd66;

   // Stimulus table with one entry per bus transaction
   string step_name [$];
   logic  step_we [$];
   addr_t step_adr [$];
   data_t step_dat [$];
   data_t step_exp [$];

   opc_system #(.RAM_AW(RAM_AW), .REFRESH_BITS(REFRESH_BITS)) i_dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack),
      .sw       (sw),
      .led      (led),
      .rxd      (rxd),
      .txd      (txd),
      .seg      (seg),
      .an       (an)
   );

   // Serial loopback
   assign rxd = txd;

   initial clk = 1'b0;
   always #20 clk = ~clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1103515245 + 32'd12345;
   endfunction

   task automatic print_counts();
      $display("checks: %0d, errors: %0d", checks, errors);
   endtask

   task automatic abort_on_timeout(input string what);
      errors++;
      $display("%s", what);
      print_counts();
      $display("tests failed");
      $finish;
   endtask

   task automatic compare_word(input string name, input data_t exp, input data_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERROR %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic add_step(input string name, input logic we, input addr_t adr,
                           input data_t dat, input data_t exp);
      step_name.push_back(name);
      step_we.push_back(we);
      step_adr.push_back(adr);
      step_dat.push_back(dat);
      step_exp.push_back(exp);
   endtask

   // One Wishbone classic transaction with ack expected one cycle after stb
   task automatic bus_cycle(input logic we, input addr_t adr, input data_t dat,
                            output data_t rdata);
      int waited;
      @(posedge clk);
      #2;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = dat;
      waited   = 0;
      @(posedge clk);
      #1;
      while (!wb_ack) begin
         waited++;
         if (waited >= ACK_LIMIT) begin
            abort_on_timeout($sformatf("no ack from address %h", adr));
         end
         @(posedge clk);
         #1;
      end
      rdata = wb_dat_r;
      // The request stays up until the ack has been seen at a clock edge
      @(posedge clk);
      #2;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      compare_word($sformatf("ack latency at %h", adr), 16'd1, data_t'(waited + 1));
   endtask

   task automatic poll_status(input data_t mask, input data_t want, input string what);
      data_t st;
      int    polls;
      polls = 0;
      bus_cycle(1'b0, UART_STATUS, '0, st);
      while ((st & mask) != want) begin
         polls++;
         if (polls >= POLL_LIMIT) begin
            abort_on_timeout(what);
         end
         bus_cycle(1'b0, UART_STATUS, '0, st);
      end
   endtask

   // Whenever a single digit is lit, seg must show that digit's nibble
   task automatic watch_digits(input string name, input data_t value);
      int      digit;
      int      seen;
      nibble_t nib;
      seen = 0;
      for (int c = 0; c < 1024; c++) begin
         @(posedge clk);
         #1;
         if ($countones(~an) == 1) begin
            for (int k = 0; k < 4; k++) begin
               if (!an[k]) begin
                  digit = k;
               end
            end
            nib = value[4*digit +: 4];
            seen++;
            checks++;
            if (seg !== SEG_FONT[nib]) begin
               errors++;
               $display("ERROR %s digit %0d: expected %h, actual %h",
                        name, digit, SEG_FONT[nib], seg);
            end
         end
      end
      if (seen == 0) begin
         errors++;
         $display("%s: no single lit digit seen in 1024 cycles", name);
      end
   endtask

   task automatic count_lit_cycles(input nibble_t duty);
      data_t rdata;
      int    lit;
      bus_cycle(1'b1, DISP_CTRL, {12'h000, duty}, rdata);
      lit = 0;
      for (int c = 0; c < 1024; c++) begin
         @(posedge clk);
         #1;
         if (an != 4'hF) begin
            lit++;
         end
      end
      compare_word($sformatf("duty %0d lit cycles", duty),
                   data_t'(64 * (int'(duty) + 1)), data_t'(lit));
   endtask

   task automatic build_table();
      addr_t adr;
      data_t dat;
      add_step("reset control", 1'b0, DISP_CTRL, '0, 16'h000F);
      add_step("reset value", 1'b0, DISP_BASE, '0, 16'h0000);
      add_step("reset uart status", 1'b0, UART_STATUS, '0, 16'h0000);
      add_step("ram low write", 1'b1, 16'h0000, 16'hA5A5, '0);
      add_step("ram high write", 1'b1, RAM_MASK, 16'h5A5A, '0);
      add_step("ram low read", 1'b0, 16'h0000, '0, 16'hA5A5);
      add_step("ram high read", 1'b0, RAM_MASK, '0, 16'h5A5A);
      // 8000 would alias RAM word 0 if the decoder let it through
      add_step("unmapped read", 1'b0, 16'h8000, '0, UNMAPPED_DATA);
      add_step("unmapped write", 1'b1, 16'h8000, 16'h1234, '0);
      add_step("unmapped read after write", 1'b0, 16'h8000, '0, UNMAPPED_DATA);
      add_step("ram word 0 untouched", 1'b0, 16'h0000, '0, 16'hA5A5);
      add_step("unmapped FE0C", 1'b0, 16'hFE0C, '0, UNMAPPED_DATA);
      for (int i = 0; i < 4; i++) begin
         rng_state = lcg_next(rng_state);
         adr = rng_state[31:16] & RAM_MASK;
         rng_state = lcg_next(rng_state);
         dat = rng_state[31:16];
         add_step($sformatf("ram random write %0d", i), 1'b1, adr, dat, '0);
         add_step($sformatf("ram random read %0d", i), 1'b0, adr, '0, dat);
      end
   endtask

   initial begin
      data_t rdata;
      data_t value;
      rst_n    = 1'b0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      sw       = 8'h00;
      repeat (10) @(posedge clk);
      #2;
      rst_n = 1'b1;

      compare_word("txd idle after reset", 16'h0001, {15'b0, txd});

      build_table();
      for (int i = 0; i < step_name.size(); i++) begin
         bus_cycle(step_we[i], step_adr[i], step_dat[i], rdata);
         if (!step_we[i]) begin
            compare_word(step_name[i], step_exp[i], rdata);
         end
      end

      // UART loopback one byte at a time
      for (int i = 0; i < 4; i++) begin
         bus_cycle(1'b1, UART_BASE, {8'h00, UART_BYTES[i]}, rdata);
         bus_cycle(1'b0, UART_STATUS, '0, rdata);
         compare_word($sformatf("uart busy after %h", UART_BYTES[i]), 16'h0002, rdata);
         poll_status(16'h0001, 16'h0001, "timeout waiting for a received UART byte");
         bus_cycle(1'b0, UART_BASE, '0, rdata);
         compare_word($sformatf("uart byte %h", UART_BYTES[i]),
                      {8'h00, UART_BYTES[i]}, rdata);
         bus_cycle(1'b0, UART_STATUS, '0, rdata);
         compare_word("uart rx valid cleared", 16'h0000, rdata & 16'h0001);
         poll_status(16'h0002, 16'h0000, "timeout waiting for the UART transmitter");
      end

      // Register source with one fixed and one random value
      rng_state = lcg_next(rng_state);
      for (int i = 0; i < 2; i++) begin
         value = (i == 0) ? 16'h4D9E : rng_state[31:16];
         bus_cycle(1'b1, DISP_BASE, value, rdata);
         bus_cycle(1'b0, DISP_BASE, '0, rdata);
         compare_word("display value readback", value, rdata);
         watch_digits($sformatf("digits of %h", value), value);
      end

      // Switch source
      @(posedge clk);
      #2;
      sw = 8'hB6;
      bus_cycle(1'b1, DISP_CTRL, 16'h001F, rdata);
      bus_cycle(1'b0, DISP_CTRL, '0, rdata);
      compare_word("control readback", 16'h001F, rdata);
      compare_word("led mirrors sw", {8'h00, sw}, {8'h00, led});
      watch_digits("switch digits", {8'h00, sw});

      count_lit_cycles(4'd0);
      count_lit_cycles(4'd7);
      count_lit_cycles(4'd15);

      print_counts();
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

//--- src.f
src/opc_pkg.sv
src/wb_bus_if.sv
src/bus_decoder.sv
src/ram_block.sv
src/uart.sv
src/display_regs.sv
src/seven_seg_display.sv
src/opc_system.sv
tb/tb_opc_system.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP        := tb_opc_system
RTL_TOP    := opc_system
FILELIST   := src.f
OBJ_DIR    := obj_dir
PASS_MSG   := all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
